// File: tb.f
+incdir+verif
source/stack_pkg.sv
source/flit_assembler.sv
source/packet_merger.sv
source/stack_core.sv
verif/stack_core_tb.sv

// File: Bender.yml
package:
  name: stack_core

sources:
  # routing core RTL, package first
  - files:
      - source/stack_pkg.sv
      - source/flit_assembler.sv
      - source/packet_merger.sv
      - source/stack_core.sv

  # testbench with its included model
  - target: test
    include_dirs:
      - verif
    files:
      - verif/stack_core_tb.sv

// File: verif/stack_model.svh
`ifndef stack_model_svh
`define stack_model_svh

// expected words per side, in arrival order
word_t top_exp[$];
word_t bot_exp[$];

// first flit of a pair, per side
logic                 top_half_ok = 1'b0;   // upper half waiting
logic                 bot_half_ok = 1'b0;
logic [payload_w-1:0] top_half;
logic [payload_w-1:0] bot_half;

// pairing rule, applied to each accepted flit
task automatic model_flit(input logic is_top, input flit_t f);
	word_t                w;
	logic                 have;
	logic [payload_w-1:0] half;
	have = is_top ? top_half_ok : bot_half_ok;
	half = is_top ? top_half : bot_half;
	if (!have && !f.tail) begin
		// first flit, keep the upper half
		if (is_top) begin
			top_half = f.payload;
			top_half_ok = 1'b1;
		end else begin
			bot_half = f.payload;
			bot_half_ok = 1'b1;
		end
	end else if (have) begin
		w.data = {half, f.payload};   // first above second
		w.last = f.tail;              // tail on second flit ends the packet
		if (is_top) begin
			top_exp.push_back(w);
			top_half_ok = 1'b0;
		end else begin
			bot_exp.push_back(w);
			bot_half_ok = 1'b0;
		end
	end
	// tail on a first flit is a resync, no word and pairing stays fresh
endtask

// one compare for every checked value
task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	if (got !== exp) begin
		$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end_with_failure();
	end
endtask

`endif

// File: verif/stack_core_tb.sv
`timescale 1ns/1ns
// random flits from both neighbors, checked word by word at the BD side
module stack_core_tb;
	import stack_pkg::*;

	localparam int n_packets = 60;   // per side

	logic     osc;
	logic     reset;
	flit_t    top_flit;
	logic     top_valid;
	logic     top_ready;
	flit_t    bot_flit;
	logic     bot_valid;
	logic     bot_ready;
	bd_word_t bd_word;
	logic     bd_valid;
	logic     bd_ready;

	flit_t       top_flits[$];   // whole stimulus, built before reset ends
	flit_t       bot_flits[$];
	int          top_sent = 0;    // flits accepted so far
	int          bot_sent = 0;
	int          top_shown = -1;  // index of the flit on the link
	int          bot_shown = -1;
	int          cycles = 0;
	int          limit = 0;       // timeout in cycles
	logic        running = 1'b0;  // drivers active
	logic        held = 1'b0;     // BD stalled on the last edge
	bd_word_t    held_word;
	logic        prev_last = 1'b1;
	logic        prev_side = 1'b0;
	logic [31:0] rnd;

	`include "stack_model.svh"

	stack_core UUT (
		.osc       (osc),
		.reset     (reset),
		.top_flit  (top_flit),
		.top_valid (top_valid),
		.top_ready (top_ready),
		.bot_flit  (bot_flit),
		.bot_valid (bot_valid),
		.bot_ready (bot_ready),
		.bd_word   (bd_word),
		.bd_valid  (bd_valid),
		.bd_ready  (bd_ready)
	);

	task automatic end_with_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic push_flit(input logic is_top, input flit_t f);
		if (is_top)
			top_flits.push_back(f);
		else
			bot_flits.push_back(f);
	endtask

	// random packets of 1 to 4 words, resync flit before some of them
	task automatic build_packets(input logic is_top);
		flit_t f;
		int    n_words;
		for (int p = 0; p < n_packets; p++) begin
			if (p > 0 && ($urandom % 4) == 0) begin
				rnd = $urandom;
				f.tail = 1'b1;   // resync
				f.payload = rnd[payload_w-1:0];
				push_flit(is_top, f);
			end
			n_words = 1 + $urandom % 4;
			for (int w = 0; w < n_words; w++) begin
				rnd = $urandom;
				f.tail = 1'b0;
				f.payload = rnd[payload_w-1:0];
				push_flit(is_top, f);
				rnd = $urandom;
				f.tail = (w == n_words - 1);   // packet end on second flit
				f.payload = rnd[payload_w-1:0];
				push_flit(is_top, f);
			end
		end
	endtask

	task automatic check_idle();
		compare_value("bd_valid", bd_valid, 0);
		compare_value("top_ready", top_ready, 1);
		compare_value("bot_ready", bot_ready, 1);
	endtask

	// BD word against the head of its side's queue
	task automatic check_bd_word();
		word_t want;
		if (!prev_last)
			compare_value("bd_word.side", bd_word.side, prev_side);   // no interleave
		if (bd_word.side == side_top) begin
			if (top_exp.size() == 0) begin
				$display("BD word from the top side arrived with no top word expected");
				end_with_failure();
			end
			want = top_exp.pop_front();
		end else begin
			if (bot_exp.size() == 0) begin
				$display("BD word from the bottom side arrived with no bottom word expected");
				end_with_failure();
			end
			want = bot_exp.pop_front();
		end
		compare_value("bd_word.data", bd_word.data, want.data);
		compare_value("bd_word.last", bd_word.last, want.last);
		prev_last = bd_word.last;
		prev_side = bd_word.side;
	endtask

	initial begin
		osc = 1'b0;
		forever #50 osc = ~osc;
	end

	// drivers, all inputs change on the falling edge
	always @(negedge osc) begin
		if (running) begin
			bd_ready = ($urandom % 3) != 0;   // stall about one cycle in three
			if (top_valid && top_sent > top_shown)
				top_valid = 1'b0;   // taken on the last edge
			if (!top_valid && top_sent < top_flits.size() && ($urandom % 4) != 0) begin
				top_flit = top_flits[top_sent];
				top_shown = top_sent;
				top_valid = 1'b1;
			end
			if (bot_valid && bot_sent > bot_shown)
				bot_valid = 1'b0;
			if (!bot_valid && bot_sent < bot_flits.size() && ($urandom % 4) != 0) begin
				bot_flit = bot_flits[bot_sent];
				bot_shown = bot_sent;
				bot_valid = 1'b1;
			end
		end
	end

	// monitor, reads pre-edge values on the rising edge
	always @(posedge osc) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, the DUT stopped moving words", cycles);
			end_with_failure();
		end
		if (!reset) begin
			if (top_valid && top_ready) begin
				model_flit(1'b1, top_flit);
				top_sent++;
			end
			if (bot_valid && bot_ready) begin
				model_flit(1'b0, bot_flit);
				bot_sent++;
			end
			if (held) begin
				compare_value("bd_valid", bd_valid, 1);
				compare_value("bd_word", bd_word, held_word);   // frozen while stalled
			end
			held = bd_valid && !bd_ready;
			held_word = bd_word;
			if (bd_valid && bd_ready)
				check_bd_word();
		end
	end

	initial begin
		rnd = $urandom(32'h27a7);   // seed once
		reset = 1'b1;
		top_flit = '0;
		top_valid = 1'b0;
		bot_flit = '0;
		bot_valid = 1'b0;
		bd_ready = 1'b0;
		build_packets(1'b1);
		build_packets(1'b0);
		limit = 8 * (top_flits.size() + bot_flits.size()) + 200;
		for (int i = 0; i < 16; i++) begin
			@(negedge osc);
			check_idle();
		end
		reset = 1'b0;
		@(negedge osc);
		check_idle();   // cycle after reset
		@(posedge osc);
		running = 1'b1;
		while (!(top_sent == top_flits.size() && bot_sent == bot_flits.size()
				&& top_exp.size() == 0 && bot_exp.size() == 0))
			@(negedge osc);
		compare_value("bd_valid", bd_valid, 0);   // no extra word behind the last one
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: source/stack_core.sv
`timescale 1ns/1ns
// routing core, neighbor boards toward the BD chip
module stack_core (
	input  logic                osc,         // single clock for the core
	input  logic                reset,       // sync, active high
	input  stack_pkg::flit_t    top_flit,    // from board above
	input  logic                top_valid,
	output logic                top_ready,
	input  stack_pkg::flit_t    bot_flit,    // from board below
	input  logic                bot_valid,
	output logic                bot_ready,
	output stack_pkg::bd_word_t bd_word,     // toward BD
	output logic                bd_valid,
	input  logic                bd_ready
);
	import stack_pkg::*;

	// assembler to merger links
	word_t top_word;
	logic  top_word_valid;
	logic  top_word_ready;
	word_t bot_word;
	logic  bot_word_valid;
	logic  bot_word_ready;

	// upper neighbor
	flit_assembler top_asm (
		.osc        (osc),
		.reset      (reset),
		.flit       (top_flit),
		.flit_valid (top_valid),
		.flit_ready (top_ready),
		.word       (top_word),
		.word_valid (top_word_valid),
		.word_ready (top_word_ready)
	);

	// lower neighbor
	flit_assembler bot_asm (
		.osc        (osc),
		.reset      (reset),
		.flit       (bot_flit),
		.flit_valid (bot_valid),
		.flit_ready (bot_ready),
		.word       (bot_word),
		.word_valid (bot_word_valid),
		.word_ready (bot_word_ready)
	);

	// packet-wise round robin into the output register
	packet_merger merger (
		.osc       (osc),
		.reset     (reset),
		.top_word  (top_word),
		.top_valid (top_word_valid),
		.top_ready (top_word_ready),
		.bot_word  (bot_word),
		.bot_valid (bot_word_valid),
		.bot_ready (bot_word_ready),
		.bd_word   (bd_word),
		.bd_valid  (bd_valid),
		.bd_ready  (bd_ready)
	);

endmodule

// File: source/packet_merger.sv
`timescale 1ns/1ns
// merges top and bottom word streams, one whole packet at a time
module packet_merger (
	input  logic                osc,
	input  logic                reset,       // sync, active high
	input  stack_pkg::word_t    top_word,    // from top assembler
	input  logic                top_valid,
	output logic                top_ready,
	input  stack_pkg::word_t    bot_word,    // from bottom assembler
	input  logic                bot_valid,
	output logic                bot_ready,
	output stack_pkg::bd_word_t bd_word,     // to BD chip
	output logic                bd_valid,
	input  logic                bd_ready
);
	import stack_pkg::*;

	merge_state_e state;
	logic         rr_top;    // round-robin pointer, 1 favors top
	logic         sel_top;   // granted side this cycle
	logic         load;      // output register free for a new word
	logic         take;      // word moves into the output register
	word_t        in_word;   // word from the granted side

	// empty, or being emptied this cycle
	assign load = !bd_valid || bd_ready;

	// grant
	always_comb begin
		case (state)
			pick: begin
				// favored side if it has a word, else the other
				if (rr_top)
					sel_top = top_valid || !bot_valid;
				else
					sel_top = top_valid && !bot_valid;
			end
			stay_top: sel_top = 1'b1;   // locked until last
			stay_bot: sel_top = 1'b0;
			default:  sel_top = rr_top;
		endcase
	end

	// only the granted side ever sees ready
	assign top_ready = load && sel_top;
	assign bot_ready = load && !sel_top;

	assign take    = sel_top ? (top_ready && top_valid) : (bot_ready && bot_valid);
	assign in_word = sel_top ? top_word : bot_word;

	// packet tracking and pointer
	always_ff @(posedge osc) begin
		if (reset) begin
			state <= pick;
			rr_top <= 1'b1;   // top first after reset
		end else if (take) begin
			if (in_word.last) begin
				state <= pick;
				rr_top <= !sel_top;   // next packet favors the other side
			end else begin
				state <= sel_top ? stay_top : stay_bot;
			end
		end
	end

	// output register valid flag
	always_ff @(posedge osc) begin
		if (reset)
			bd_valid <= 1'b0;
		else if (take)
			bd_valid <= 1'b1;    // shows the cycle after the take
		else if (bd_ready)
			bd_valid <= 1'b0;    // drained, nothing new
	end

	// output register payload, tagged with its side
	always_ff @(posedge osc) begin
		if (take) begin
			bd_word.side <= sel_top ? side_top : side_bot;
			bd_word.last <= in_word.last;
			bd_word.data <= in_word.data;
		end
	end

	// BD sees a frozen word while it stalls
	bd_word_stable: assert property (
		@(posedge osc) disable iff (reset)
		bd_valid && !bd_ready |=> bd_valid && $stable(bd_word)
	) else $error("packet_merger: bd_word changed under back-pressure");

	// one side at a time
	one_ready: assert property (
		@(posedge osc) disable iff (reset)
		!(top_ready && bot_ready)
	) else $error("packet_merger: both sides ready");

endmodule

// File: source/flit_assembler.sv
`timescale 1ns/1ns
// pairs flits from one neighbor board into 20-bit words
module flit_assembler (
	input  logic             osc,          // board oscillator
	input  logic             reset,        // sync, active high
	input  stack_pkg::flit_t flit,         // from neighbor
	input  logic             flit_valid,
	output logic             flit_ready,
	output stack_pkg::word_t word,         // to merger
	output logic             word_valid,
	input  logic             word_ready
);
	import stack_pkg::*;

	asm_state_e           state;
	logic [payload_w-1:0] high_half;   // payload of the first flit
	logic                 flit_take;   // flit handshake this cycle
	logic                 word_take;   // word handshake this cycle
	logic                 high_load;   // first flit of a pair accepted
	logic                 low_load;    // second flit accepted, word completes

	// a built word that is not yet taken blocks the flit link
	assign flit_ready = !word_valid;

	assign flit_take = flit_valid && flit_ready;
	assign word_take = word_valid && word_ready;

	// tail on a first flit is a resync and loads nothing
	assign high_load = flit_take && (state == want_high) && !flit.tail;
	assign low_load  = flit_take && (state == want_low);

	// control path
	always_ff @(posedge osc) begin
		if (reset) begin
			state <= want_high;
			word_valid <= 1'b0;
		end else begin
			case (state)
				want_high: begin
					// resync flit is swallowed here, pairing restarts
					if (high_load)
						state <= want_low;
				end
				want_low: begin
					if (low_load) begin
						state <= hold;
						word_valid <= 1'b1;   // visible the cycle after
					end
				end
				hold: begin
					if (word_take) begin
						state <= want_high;
						word_valid <= 1'b0;
					end
				end
				default: begin
					state <= want_high;   // unused encoding
					word_valid <= 1'b0;
				end
			endcase
		end
	end

	// payload path
	always_ff @(posedge osc) begin
		if (high_load)
			high_half <= flit.payload;   // upper half first
		if (low_load) begin
			word.data <= {high_half, flit.payload};
			word.last <= flit.tail;      // tail on second flit ends the packet
		end
	end

	// held word must not move until the merger takes it
	word_stable: assert property (
		@(posedge osc) disable iff (reset)
		word_valid && !word_ready |=> $stable(word) && word_valid
	) else $error("flit_assembler: word changed under back-pressure");

	// no flit accepted while a word waits
	hold_blocks_flits: assert property (
		@(posedge osc) disable iff (reset)
		(state == hold) |-> !flit_ready
	) else $error("flit_assembler: flit_ready high in hold");

endmodule

// File: source/stack_pkg.sv
// shared types for the stack routing core
package stack_pkg;

	localparam int payload_w = 10;           // payload bits per flit
	localparam int data_w = 2 * payload_w;   // two flits per word

	// side tag values as seen by the BD chip
	localparam logic side_top = 1'b1;
	localparam logic side_bot = 1'b0;

	// flit from a neighbor board, 11 bits
	typedef struct packed {
		logic                 tail;     // packet end, or resync on a first flit
		logic [payload_w-1:0] payload;
	} flit_t;

	// assembled word, assembler to merger
	typedef struct packed {
		logic              last;   // last word of its packet
		logic [data_w-1:0] data;   // first payload in upper half
	} word_t;

	// word toward the BD chip
	typedef struct packed {
		logic              side;   // 1 top, 0 bottom
		logic              last;
		logic [data_w-1:0] data;
	} bd_word_t;

	// assembler FSM
	typedef enum logic [1:0] {
		want_high,   // waiting for first flit of a pair
		want_low,    // upper half stored, waiting for second
		hold         // word built, waiting for merger
	} asm_state_e;

	// merger FSM
	typedef enum logic [1:0] {
		pick,        // between packets, round-robin choice
		stay_top,    // inside a top packet
		stay_bot     // inside a bottom packet
	} merge_state_e;

endpackage
